// ==== common/stream_pkg.sv ====
// --------------------
// byte stream word layout, little endian only.
// byte 0 sits in the low bits of a word.
// keep masks are contiguous from bit 0.
// --------------------
`default_nettype none

package stream_pkg;

   // --------------------
   // word geometry.
   // --------------------

   // data bytes carried by one stream word.
   localparam int DATA_BYTES = 8;

   // a count must reach two full words, 0 to 16 bytes.
   localparam int COUNT_W = 5;

   // --------------------
   // stream types.
   // --------------------

   // one word of data, byte i at bits [8*i+7:8*i].
   typedef logic [DATA_BYTES*8-1:0] byte_data_t;

   // one valid bit per byte.
   typedef logic [DATA_BYTES-1:0] byte_keep_t;

   // number of valid bytes.
   typedef logic [COUNT_W-1:0] byte_count_t;

endpackage

`default_nettype wire

// ==== common/join_pkg.sv ====
// --------------------
// definitions of the header/payload joiner.
// keep_to_count expects a contiguous mask from bit 0.
// --------------------
`default_nettype none

package join_pkg;

   import stream_pkg::*;

   // --------------------
   // joiner states.
   // --------------------

   // hdr    merge header words into the output.
   // pyld   append payload words behind the header.
   // flush  send the last carry bytes.
   // drop   discard the payload of a dropped header.
   typedef enum logic [1:0] {
      HDR,
      PYLD,
      FLUSH,
      DROP
   } join_state_t;

   // --------------------
   // helpers.
   // --------------------

   // byte count of a contiguous keep mask.
   // the highest set bit gives the count.
   function automatic byte_count_t keep_to_count(input byte_keep_t keep);
      byte_count_t count;
      count = '0;
      for (int i = 0; i < DATA_BYTES; i++) begin
         if (keep[i]) begin
            count = byte_count_t'(i + 1);
         end
      end
      return count;
   endfunction

endpackage

`default_nettype wire

// ==== logic/stream_pipe.sv ====
// --------------------
// valid/ready register slice with a one-entry skid buffer.
// full rate, one cycle latency, in_ready comes from a flop.
// --------------------
`timescale 1ns/1ns
`default_nettype none

module stream_pipe
   import stream_pkg::*;
(
   input  logic       clk,
   input  logic       resetn,

   input  logic       in_valid,
   output logic       in_ready,
   input  byte_data_t in_data,
   input  byte_keep_t in_keep,
   input  logic       in_last,

   output logic       out_valid,
   input  logic       out_ready,
   output byte_data_t out_data,
   output byte_keep_t out_keep,
   output logic       out_last
);

   // skid entry, holds a word that arrived while the output stalled.
   logic       skid_valid;
   byte_data_t skid_data;
   byte_keep_t skid_keep;
   logic       skid_last;

   logic       in_fire;
   logic       main_load;

   // ready drops only while the skid entry is full.
   assign in_ready  = !skid_valid;
   assign in_fire   = in_valid && in_ready;

   // main register may take a new word when empty or being drained.
   assign main_load = !out_valid || out_ready;

   // --------------------
   // control.
   // --------------------
   always_ff @(posedge clk) begin
      if (!resetn) begin
         out_valid  <= 1'b0;
         skid_valid <= 1'b0;
      end else begin
         if (main_load) begin
            // skid word goes first, else the new input word.
            out_valid  <= skid_valid || in_fire;
            skid_valid <= 1'b0;
         end else if (in_fire) begin
            // output stalled, park the word.
            skid_valid <= 1'b1;
         end
      end
   end

   // --------------------
   // payload.
   // --------------------
   always_ff @(posedge clk) begin
      if (main_load) begin
         if (skid_valid) begin
            out_data <= skid_data;
            out_keep <= skid_keep;
            out_last <= skid_last;
         end else if (in_fire) begin
            out_data <= in_data;
            out_keep <= in_keep;
            out_last <= in_last;
         end
      end else if (in_fire) begin
         skid_data <= in_data;
         skid_keep <= in_keep;
         skid_last <= in_last;
      end
   end

endmodule

`default_nettype wire

// ==== join/byte_merge.sv ====
// --------------------
// packs carry bytes and an incoming word into one word plus new carry.
// carry_count must stay below 8 when in_keep is not empty.
// --------------------
`timescale 1ns/1ns
`default_nettype none

module byte_merge
   import stream_pkg::*;
   import join_pkg::*;
(
   input  byte_data_t  carry_data,
   input  byte_count_t carry_count,
   input  byte_data_t  in_data,
   input  byte_keep_t  in_keep,

   output byte_data_t  word_data,
   output byte_keep_t  word_keep,
   output logic        word_full,
   output byte_data_t  next_carry_data,
   output byte_count_t next_carry_count
);

   byte_count_t                  in_count;
   byte_count_t                  total;
   byte_data_t                   carry_masked;
   byte_data_t                   in_masked;
   logic [2*DATA_BYTES*8-1:0]    merged;

   always_comb begin
      in_count = keep_to_count(in_keep);
      total    = carry_count + in_count;

      // zero every byte outside its count, so the or below is clean.
      for (int i = 0; i < DATA_BYTES; i++) begin
         carry_masked[i*8 +: 8] = (i < carry_count) ? carry_data[i*8 +: 8] : 8'h00;
         in_masked[i*8 +: 8]    = in_keep[i] ? in_data[i*8 +: 8] : 8'h00;
      end

      // incoming bytes land right above the carry.
      merged = {{DATA_BYTES*8{1'b0}}, carry_masked} |
               ({{DATA_BYTES*8{1'b0}}, in_masked} << {carry_count, 3'b000});

      word_data = merged[DATA_BYTES*8-1:0];
      word_full = (total >= byte_count_t'(DATA_BYTES));
      for (int i = 0; i < DATA_BYTES; i++) begin
         word_keep[i] = (i < total);
      end

      // full word leaves the upper half as carry, else everything stays.
      if (word_full) begin
         next_carry_data  = merged[2*DATA_BYTES*8-1:DATA_BYTES*8];
         next_carry_count = total - byte_count_t'(DATA_BYTES);
      end else begin
         next_carry_data  = word_data;
         next_carry_count = total;
      end
   end

endmodule

`default_nettype wire

// ==== join/join_fsm.sv ====
// --------------------
// sequences header, payload, flush and drop, holds the carry bytes.
// a zero-keep header last word is taken as a drop, legal only alone.
// output is combinational toward a register slice.
// --------------------
`timescale 1ns/1ns
`default_nettype none

module join_fsm
   import stream_pkg::*;
   import join_pkg::*;
(
   input  logic       clk,
   input  logic       resetn,

   input  logic       hdr_valid,
   output logic       hdr_ready,
   input  byte_data_t hdr_data,
   input  byte_keep_t hdr_keep,
   input  logic       hdr_last,

   input  logic       pyld_valid,
   output logic       pyld_ready,
   input  byte_data_t pyld_data,
   input  byte_keep_t pyld_keep,
   input  logic       pyld_last,

   output logic       out_valid,
   input  logic       out_ready,
   output byte_data_t out_data,
   output byte_keep_t out_keep,
   output logic       out_last
);

   join_state_t state;
   join_state_t state_next;

   // carry bytes not yet sent, low aligned.
   byte_data_t  carry_data;
   byte_count_t carry_count;
   logic        carry_load;
   logic        carry_clear;

   byte_data_t  merge_data;
   byte_keep_t  merge_keep;
   byte_data_t  word_data;
   byte_keep_t  word_keep;
   logic        word_full;
   byte_data_t  next_carry_data;
   byte_count_t next_carry_count;

   logic        hdr_drop;
   logic        fits;
   logic        consume;

   // --------------------
   // merge datapath.
   // --------------------

   // flush feeds no input bytes, so the merge returns the carry itself.
   assign merge_data = (state == PYLD) ? pyld_data : hdr_data;
   always_comb begin
      case (state)
         HDR:     merge_keep = hdr_keep;
         PYLD:    merge_keep = pyld_keep;
         default: merge_keep = '0;
      endcase
   end

   byte_merge byte_merge_i (
      .carry_data       (carry_data),
      .carry_count      (carry_count),
      .in_data          (merge_data),
      .in_keep          (merge_keep),
      .word_data        (word_data),
      .word_keep        (word_keep),
      .word_full        (word_full),
      .next_carry_data  (next_carry_data),
      .next_carry_count (next_carry_count)
   );

   assign out_data = word_data;
   assign out_keep = word_keep;

   // empty header word marks a dropped packet.
   assign hdr_drop = hdr_last && (keep_to_count(hdr_keep) == '0);

   // all merged bytes fit into one word, no flush needed.
   assign fits = !word_full || (next_carry_count == '0);

   // --------------------
   // next state.
   // --------------------
   always_comb begin
      state_next  = state;
      hdr_ready   = 1'b0;
      pyld_ready  = 1'b0;
      out_valid   = 1'b0;
      out_last    = 1'b0;
      carry_load  = 1'b0;
      carry_clear = 1'b0;
      consume     = 1'b0;
      case (state)
         HDR: begin
            if (hdr_valid) begin
               if (hdr_drop) begin
                  hdr_ready   = 1'b1;
                  carry_clear = 1'b1;
                  state_next  = DROP;
               end else begin
                  // a word that only grows the carry needs no output slot.
                  out_valid  = word_full;
                  consume    = !word_full || out_ready;
                  hdr_ready  = consume;
                  carry_load = consume;
                  if (consume && hdr_last) begin
                     state_next = PYLD;
                  end
               end
            end
         end
         PYLD: begin
            if (pyld_valid) begin
               out_valid  = word_full || pyld_last;
               out_last   = pyld_last && fits;
               consume    = !out_valid || out_ready;
               pyld_ready = consume;
               if (consume) begin
                  if (pyld_last && fits) begin
                     carry_clear = 1'b1;
                     state_next  = HDR;
                  end else begin
                     carry_load = 1'b1;
                     if (pyld_last) begin
                        state_next = FLUSH;
                     end
                  end
               end
            end
         end
         FLUSH: begin
            // remainder after the payload last word.
            out_valid = 1'b1;
            out_last  = 1'b1;
            if (out_ready) begin
               carry_clear = 1'b1;
               state_next  = HDR;
            end
         end
         DROP: begin
            pyld_ready = 1'b1;
            if (pyld_valid && pyld_last) begin
               carry_clear = 1'b1;
               state_next  = HDR;
            end
         end
         default: begin
            state_next = HDR;
         end
      endcase
   end

   // --------------------
   // registers.
   // --------------------
   always_ff @(posedge clk) begin
      if (!resetn) begin
         state       <= HDR;
         carry_count <= '0;
      end else begin
         state <= state_next;
         if (carry_clear) begin
            carry_count <= '0;
         end else if (carry_load) begin
            carry_count <= next_carry_count;
         end
      end
   end

   // bytes above carry_count are masked in the merge.
   always_ff @(posedge clk) begin
      if (carry_load) begin
         carry_data <= next_carry_data;
      end
   end

endmodule

`default_nettype wire

// ==== join/pkt_join.sv ====
// --------------------
// joins a header stream and a payload stream into one packet stream.
// one payload packet is read per header packet.
// all three streams pass a register slice.
// --------------------
`timescale 1ns/1ns
`default_nettype none

module pkt_join
   import stream_pkg::*;
(
   input  logic       clk,
   input  logic       resetn,

   input  logic       hdr_valid,
   output logic       hdr_ready,
   input  byte_data_t hdr_data,
   input  byte_keep_t hdr_keep,
   input  logic       hdr_last,

   input  logic       pyld_valid,
   output logic       pyld_ready,
   input  byte_data_t pyld_data,
   input  byte_keep_t pyld_keep,
   input  logic       pyld_last,

   output logic       out_valid,
   input  logic       out_ready,
   output byte_data_t out_data,
   output byte_keep_t out_keep,
   output logic       out_last
);

   // registered header stream.
   logic       hdr_p_valid;
   logic       hdr_p_ready;
   byte_data_t hdr_p_data;
   byte_keep_t hdr_p_keep;
   logic       hdr_p_last;

   // registered payload stream.
   logic       pyld_p_valid;
   logic       pyld_p_ready;
   byte_data_t pyld_p_data;
   byte_keep_t pyld_p_keep;
   logic       pyld_p_last;

   // joined stream before the output slice.
   logic       join_valid;
   logic       join_ready;
   byte_data_t join_data;
   byte_keep_t join_keep;
   logic       join_last;

   stream_pipe hdr_pipe_i (
      .clk       (clk),
      .resetn    (resetn),
      .in_valid  (hdr_valid),
      .in_ready  (hdr_ready),
      .in_data   (hdr_data),
      .in_keep   (hdr_keep),
      .in_last   (hdr_last),
      .out_valid (hdr_p_valid),
      .out_ready (hdr_p_ready),
      .out_data  (hdr_p_data),
      .out_keep  (hdr_p_keep),
      .out_last  (hdr_p_last)
   );

   stream_pipe pyld_pipe_i (
      .clk       (clk),
      .resetn    (resetn),
      .in_valid  (pyld_valid),
      .in_ready  (pyld_ready),
      .in_data   (pyld_data),
      .in_keep   (pyld_keep),
      .in_last   (pyld_last),
      .out_valid (pyld_p_valid),
      .out_ready (pyld_p_ready),
      .out_data  (pyld_p_data),
      .out_keep  (pyld_p_keep),
      .out_last  (pyld_p_last)
   );

   join_fsm join_fsm_i (
      .clk        (clk),
      .resetn     (resetn),
      .hdr_valid  (hdr_p_valid),
      .hdr_ready  (hdr_p_ready),
      .hdr_data   (hdr_p_data),
      .hdr_keep   (hdr_p_keep),
      .hdr_last   (hdr_p_last),
      .pyld_valid (pyld_p_valid),
      .pyld_ready (pyld_p_ready),
      .pyld_data  (pyld_p_data),
      .pyld_keep  (pyld_p_keep),
      .pyld_last  (pyld_p_last),
      .out_valid  (join_valid),
      .out_ready  (join_ready),
      .out_data   (join_data),
      .out_keep   (join_keep),
      .out_last   (join_last)
   );

   // output slice cuts the combinational path out of the FSM.
   stream_pipe out_pipe_i (
      .clk       (clk),
      .resetn    (resetn),
      .in_valid  (join_valid),
      .in_ready  (join_ready),
      .in_data   (join_data),
      .in_keep   (join_keep),
      .in_last   (join_last),
      .out_valid (out_valid),
      .out_ready (out_ready),
      .out_data  (out_data),
      .out_keep  (out_keep),
      .out_last  (out_last)
   );

endmodule

`default_nettype wire

// ==== dv/pkt_join_properties.sv ====
// --------------------
// output stream protocol checks, bound into pkt_join.
// --------------------
`timescale 1ns/1ns
`default_nettype none

module pkt_join_properties
   import stream_pkg::*;
(
   input logic       clk,
   input logic       resetn,
   input logic       out_valid,
   input logic       out_ready,
   input byte_data_t out_data,
   input byte_keep_t out_keep,
   input logic       out_last
);

   // a stalled word is held until taken.
   property stall_holds_word;
      @(posedge clk) disable iff (!resetn)
         out_valid && !out_ready |=>
            out_valid && $stable(out_data) && $stable(out_keep) && $stable(out_last);
   endproperty

   // only the last word of a packet may be short.
   property keep_full_before_last;
      @(posedge clk) disable iff (!resetn)
         out_valid && !out_last |-> (out_keep == '1);
   endproperty

   // reset empties the output slice.
   property no_valid_in_reset;
      @(posedge clk) !resetn |=> !out_valid;
   endproperty

   stall_holds_word_a: assert property (stall_holds_word)
      else $error("output word changed while out_ready was low");
   keep_full_before_last_a: assert property (keep_full_before_last)
      else $error("short keep on a word without last");
   no_valid_in_reset_a: assert property (no_valid_in_reset)
      else $error("out_valid high during reset");

endmodule

bind pkt_join pkt_join_properties pkt_join_properties_i (
   .clk       (clk),
   .resetn    (resetn),
   .out_valid (out_valid),
   .out_ready (out_ready),
   .out_data  (out_data),
   .out_keep  (out_keep),
   .out_last  (out_last)
);

`default_nettype wire

// ==== dv/pkt_join_tb.sv ====
// --------------------
// testbench of pkt_join, directed and random joined packets.
// inputs change 2 ns after the rising edge, outputs are sampled on the falling edge.
// a header length of 0 stands for a dropped packet.
// --------------------
`timescale 1ns/1ns
`default_nettype none

module pkt_join_tb
   import stream_pkg::*;
();

   localparam int SEED = 13294;

   logic       clk;
   logic       resetn;

   logic       hdr_valid;
   logic       hdr_ready;
   byte_data_t hdr_data;
   byte_keep_t hdr_keep;
   logic       hdr_last;

   logic       pyld_valid;
   logic       pyld_ready;
   byte_data_t pyld_data;
   byte_keep_t pyld_keep;
   logic       pyld_last;

   logic       out_valid;
   logic       out_ready;
   byte_data_t out_data;
   byte_keep_t out_keep;
   logic       out_last;

   // bytes of the packet pair being sent.
   logic [7:0] hdr_bytes[$];
   logic [7:0] pyld_bytes[$];

   // expected output words, oldest first.
   byte_data_t exp_data_q[$];
   byte_keep_t exp_keep_q[$];
   logic       exp_last_q[$];

   // packet list, one entry per header/payload pair.
   int         pkt_test[$];
   int         pkt_hdr_len[$];
   int         pkt_pyld_len[$];

   string      test_name;
   bit         random_flow;
   int         cycle_count;
   int         cycle_limit;
   int         errors;
   int         test_errors;
   int         words_checked;
   int         tests_passed;
   int         tests_failed;

   pkt_join dut_i (
      .clk        (clk),
      .resetn     (resetn),
      .hdr_valid  (hdr_valid),
      .hdr_ready  (hdr_ready),
      .hdr_data   (hdr_data),
      .hdr_keep   (hdr_keep),
      .hdr_last   (hdr_last),
      .pyld_valid (pyld_valid),
      .pyld_ready (pyld_ready),
      .pyld_data  (pyld_data),
      .pyld_keep  (pyld_keep),
      .pyld_last  (pyld_last),
      .out_valid  (out_valid),
      .out_ready  (out_ready),
      .out_data   (out_data),
      .out_keep   (out_keep),
      .out_last   (out_last)
   );

   initial begin
      clk = 1'b0;
      forever #20 clk = ~clk;
   end

   // --------------------
   // reference model.
   // --------------------

   // header bytes then payload bytes, cut into 8-byte words.
   // a dropped header yields no word at all.
   function automatic void expected_join();
      logic [7:0] all_bytes[$];
      byte_data_t data;
      byte_keep_t keep;
      int         idx;
      if (hdr_bytes.size() == 0) begin
         return;
      end
      foreach (hdr_bytes[i]) begin
         all_bytes.push_back(hdr_bytes[i]);
      end
      foreach (pyld_bytes[i]) begin
         all_bytes.push_back(pyld_bytes[i]);
      end
      for (int w = 0; w * DATA_BYTES < all_bytes.size(); w++) begin
         data = '0;
         keep = '0;
         for (int b = 0; b < DATA_BYTES; b++) begin
            idx = w * DATA_BYTES + b;
            if (idx < all_bytes.size()) begin
               data[b*8 +: 8] = all_bytes[idx];
               keep[b]        = 1'b1;
            end
         end
         exp_data_q.push_back(data);
         exp_keep_q.push_back(keep);
         exp_last_q.push_back((w + 1) * DATA_BYTES >= all_bytes.size());
      end
   endfunction

   // words an input packet takes, a drop header still needs one.
   function automatic int words_of(input int nbytes);
      return (nbytes == 0) ? 1 : (nbytes + DATA_BYTES - 1) / DATA_BYTES;
   endfunction

   // byte lanes of a keep mask widened to a data mask.
   function automatic byte_data_t keep_mask(input byte_keep_t keep);
      byte_data_t mask;
      for (int b = 0; b < DATA_BYTES; b++) begin
         mask[b*8 +: 8] = keep[b] ? 8'hff : 8'h00;
      end
      return mask;
   endfunction

   // --------------------
   // stimulus.
   // --------------------

   // word w of the header or payload bytes, idle lanes get random filler.
   function automatic void input_word(input bit payload, input int w,
                                      output byte_data_t data, output byte_keep_t keep,
                                      output logic last);
      int n;
      int idx;
      n = payload ? pyld_bytes.size() : hdr_bytes.size();
      for (int b = 0; b < DATA_BYTES; b++) begin
         idx     = w * DATA_BYTES + b;
         keep[b] = (idx < n);
         if (idx < n) begin
            data[b*8 +: 8] = payload ? pyld_bytes[idx] : hdr_bytes[idx];
         end else begin
            data[b*8 +: 8] = 8'($urandom_range(255, 0));
         end
      end
      last = ((w + 1) * DATA_BYTES >= n);
   endfunction

   task automatic send_header();
      byte_data_t data;
      byte_keep_t keep;
      logic       last;
      bit         taken;
      for (int w = 0; w < words_of(hdr_bytes.size()); w++) begin
         // idle gaps only in the random test.
         while (random_flow && $urandom_range(3, 0) == 0) begin
            @(posedge clk);
            #2;
         end
         input_word(1'b0, w, data, keep, last);
         hdr_valid = 1'b1;
         hdr_data  = data;
         hdr_keep  = keep;
         hdr_last  = last;
         taken     = 1'b0;
         // ready is registered, its value before the edge decides the transfer.
         while (!taken) begin
            @(negedge clk);
            taken = hdr_ready;
            @(posedge clk);
            #2;
         end
         hdr_valid = 1'b0;
      end
   endtask

   task automatic send_payload();
      byte_data_t data;
      byte_keep_t keep;
      logic       last;
      bit         taken;
      for (int w = 0; w < words_of(pyld_bytes.size()); w++) begin
         while (random_flow && $urandom_range(3, 0) == 0) begin
            @(posedge clk);
            #2;
         end
         input_word(1'b1, w, data, keep, last);
         pyld_valid = 1'b1;
         pyld_data  = data;
         pyld_keep  = keep;
         pyld_last  = last;
         taken      = 1'b0;
         while (!taken) begin
            @(negedge clk);
            taken = pyld_ready;
            @(posedge clk);
            #2;
         end
         pyld_valid = 1'b0;
      end
   endtask

   // fresh random bytes, expected words queued, both streams sent side by side.
   task automatic run_packet(input int hlen, input int plen);
      hdr_bytes.delete();
      pyld_bytes.delete();
      for (int i = 0; i < hlen; i++) begin
         hdr_bytes.push_back(8'($urandom_range(255, 0)));
      end
      for (int i = 0; i < plen; i++) begin
         pyld_bytes.push_back(8'($urandom_range(255, 0)));
      end
      expected_join();
      fork
         send_header();
         send_payload();
      join
   endtask

   function automatic void add_packet(input int id, input int hlen, input int plen);
      pkt_test.push_back(id);
      pkt_hdr_len.push_back(hlen);
      pkt_pyld_len.push_back(plen);
   endfunction

   task automatic run_test(input int id, input string name, input bit random_on);
      test_name   = name;
      random_flow = random_on;
      test_errors = 0;
      for (int i = 0; i < pkt_test.size(); i++) begin
         if (pkt_test[i] == id) begin
            run_packet(pkt_hdr_len[i], pkt_pyld_len[i]);
         end
      end
      // test ends once every expected word came out.
      while (exp_data_q.size() != 0) begin
         @(posedge clk);
         #2;
      end
      random_flow = 1'b0;
      if (test_errors == 0) begin
         tests_passed++;
         $display("test %0d %s: done, no errors", id, name);
      end else begin
         tests_failed++;
         $display("test %0d %s: done, %0d errors", id, name, test_errors);
      end
   endtask

   // output back-pressure, random only in the random test.
   initial begin
      forever begin
         @(posedge clk);
         #2;
         out_ready = random_flow ? ($urandom_range(3, 0) != 0) : 1'b1;
      end
   end

   // --------------------
   // comparison.
   // --------------------

   task automatic count_error();
      errors++;
      test_errors++;
   endtask

   task automatic check_word();
      byte_data_t exp_data;
      byte_keep_t exp_keep;
      logic       exp_last;
      byte_data_t got_data;
      if (exp_data_q.size() == 0) begin
         $display("test %s: output word %h came out with no word expected",
                  test_name, out_data);
         count_error();
         return;
      end
      exp_data = exp_data_q.pop_front();
      exp_keep = exp_keep_q.pop_front();
      exp_last = exp_last_q.pop_front();
      got_data = out_data & keep_mask(exp_keep);
      words_checked++;
      if (got_data != exp_data) begin
         $display("Fail %s: data expected %h actual %h", test_name, exp_data, got_data);
         count_error();
      end
      if (out_keep != exp_keep) begin
         $display("Fail %s: keep expected %b actual %b", test_name, exp_keep, out_keep);
         count_error();
      end
      if (out_last != exp_last) begin
         $display("Fail %s: last expected %b actual %b", test_name, exp_last, out_last);
         count_error();
      end
   endtask

   // everything is stable mid cycle, a transfer happens at the next edge.
   always @(negedge clk) begin
      if (resetn && out_valid && out_ready) begin
         check_word();
      end
   end

   // run limit in cycles, set once the packet list is known.
   always @(posedge clk) begin
      cycle_count++;
      if (cycle_limit != 0 && cycle_count >= cycle_limit) begin
         $display("timeout after %0d cycles, %0d expected words never came out",
                  cycle_count, exp_data_q.size());
         $display("Something failed");
         $finish;
      end
   end

   // --------------------
   // main sequence.
   // --------------------
   initial begin
      int total_words;
      void'($urandom(SEED));
      resetn        = 1'b0;
      hdr_valid     = 1'b0;
      hdr_data      = '0;
      hdr_keep      = '0;
      hdr_last      = 1'b0;
      pyld_valid    = 1'b0;
      pyld_data     = '0;
      pyld_keep     = '0;
      pyld_last     = 1'b0;
      out_ready     = 1'b1;
      random_flow   = 1'b0;
      test_name     = "reset";
      cycle_count   = 0;
      cycle_limit   = 0;
      errors        = 0;
      test_errors   = 0;
      words_checked = 0;
      tests_passed  = 0;
      tests_failed  = 0;

      add_packet(1, 16, 20);
      add_packet(2, 5, 3);
      add_packet(2, 5, 11);
      add_packet(2, 5, 12);
      // zero-keep header first, then a normal pair.
      add_packet(3, 0, 13);
      add_packet(3, 6, 9);
      for (int i = 0; i < 40; i++) begin
         add_packet(4, $urandom_range(24, 1), $urandom_range(24, 1));
      end
      for (int i = 0; i < 4; i++) begin
         add_packet(5, 1, 1);
      end

      total_words = 0;
      for (int i = 0; i < pkt_test.size(); i++) begin
         total_words += words_of(pkt_hdr_len[i]) + words_of(pkt_pyld_len[i]);
      end
      cycle_limit = 4 * total_words + 200;

      repeat (16) @(posedge clk);
      #2;
      resetn = 1'b1;

      run_test(1, "hdr16_pyld20", 1'b0);
      run_test(2, "hdr5_carry", 1'b0);
      run_test(3, "drop_then_join", 1'b0);
      run_test(4, "random_flow", 1'b1);
      run_test(5, "back_to_back", 1'b0);

      // any stray word would show up here.
      test_name = "idle";
      repeat (10) @(posedge clk);
      $display("tests passed %0d, failed %0d, words checked %0d, errors %0d",
               tests_passed, tests_failed, words_checked, errors);
      if (errors == 0) begin
         $display("Everything OK");
      end else begin
         $display("Something failed");
      end
      $finish;
   end

endmodule

`default_nettype wire

// ==== vlog.f ====
common/stream_pkg.sv
common/join_pkg.sv
logic/stream_pipe.sv
join/byte_merge.sv
join/join_fsm.sv
join/pkt_join.sv
dv/pkt_join_properties.sv
dv/pkt_join_tb.sv

// ==== Bender.yml ====
package:
  name: pkt_join

sources:
  - files:
      - common/stream_pkg.sv
      - common/join_pkg.sv
      - logic/stream_pipe.sv
      - join/byte_merge.sv
      - join/join_fsm.sv
      - join/pkt_join.sv
  - target: test
    files:
      - dv/pkt_join_properties.sv
      - dv/pkt_join_tb.sv
